// ==== cpu16.f ====
+incdir+.
cpu16_isa_pkg.sv
cpu16_bus_pkg.sv
control.sv
alu.sv
reg_file.sv
pc_unit.sv
data_mem.sv
cpu16_core.sv
tb_cpu16.sv

// ==== tb_cpu16.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu16_macros.svh"

module tb_cpu16 import cpu16_isa_pkg::*; import cpu16_bus_pkg::*; ();

  localparam int PROG_LEN = 45;
  localparam int TIMEOUT  = 4000;  // Reset plus 45 instructions with gaps and stalls

  logic         clk, rst;
  logic [15:0]  fetch_pc;
  logic         inst_valid, inst_ready, retire_valid, retire_ready;
  inst_beat_t   inst;
  retire_t      retire;

  logic [15:0]  prog [64];
  int           n_prog;
  logic [15:0]  lfsr = 16'd28;
  retire_t      exp_q [$];
  int           cycles;
  logic         held;              // Record was stalled last edge
  retire_t      held_rec;

  // ISA model state
  logic [15:0]  m_regs [16];
  logic [15:0]  m_mem [256];
  flags_t       m_flags;
  logic [15:0]  m_pc;

  cpu16_core dut0 (
    .clk(clk), .rst(rst), .fetch_pc(fetch_pc), .inst_valid(inst_valid), .inst(inst),
    .inst_ready(inst_ready), .retire_valid(retire_valid), .retire(retire),
    .retire_ready(retire_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////
  function automatic logic [7:0] rand_bits(input int n);  // One LFSR step per bit
    logic [7:0] r;
    logic       fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[6:0], fb};
    end
    return r;
  endfunction

  task automatic emit(input logic [15:0] w);
    prog[n_prog] = w;
    n_prog++;
  endtask

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_field(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (exp === act) else
      fail_now($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
  endtask

  function automatic logic cond_holds(input logic [3:0] c, input flags_t f);
    case (c)
      4'd0:  return f.z;
      4'd1:  return !f.z;
      4'd2:  return f.c;
      4'd3:  return !f.c;
      4'd4:  return f.l;
      4'd5:  return !f.l;
      4'd6:  return f.n;
      4'd7:  return !f.n;
      4'd8:  return f.f;
      4'd9:  return !f.f;
      4'd10: return !f.z && !f.l;
      4'd11: return f.z || f.l;
      4'd12: return !f.z && !f.n;
      4'd13: return f.z || f.n;
      4'd14: return 1'b1;       // UC
      default: return 1'b0;     // NV
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // ISA reference model
  //////////////////////////////////////////////////////////////////////
  task automatic alu_model(input logic [3:0] aop, input logic [15:0] a, input logic [15:0] b,
                           output logic [15:0] res);
    logic [16:0] s;
    logic        cin;
    cin = m_flags.c;
    res = a;
    case (aop)
      4'b0001: res = a & b;
      4'b0010: res = a | b;
      4'b0011: res = a ^ b;
      4'b1101: res = b;
      4'b0110: res = a + b;      // ADDU leaves flags untouched
      4'b0101, 4'b0111: begin
        s = a + b + ((aop == 4'b0111) ? cin : 1'b0);
        res = s[15:0];
        m_flags.c = s[16];
        m_flags.f = (a[15] == b[15]) && (res[15] != a[15]);
        m_flags.z = (res == 0);
        m_flags.n = res[15];
      end
      4'b1001, 4'b1010: begin
        s = {1'b0, a} - {1'b0, b} - ((aop == 4'b1010) ? cin : 1'b0);
        res = s[15:0];
        m_flags.c = s[16];       // Borrow
        m_flags.f = (a[15] != b[15]) && (res[15] != a[15]);
        m_flags.z = (res == 0);
        m_flags.n = res[15];
      end
      default: ;
    endcase
  endtask

  task automatic cmp_model(input logic [15:0] a, input logic [15:0] b);
    logic [15:0] d;
    d = a - b;
    m_flags.z = (a == b);
    m_flags.l = (b < a);
    m_flags.n = ($signed(b) < $signed(a));
    m_flags.f = (a[15] != b[15]) && (d[15] != a[15]);
  endtask

  task automatic model_step(input logic [15:0] w, output retire_t e);
    logic [3:0]  op, d, x, s;
    logic [15:0] av, bv, simm, res, nxt;
    logic [4:0]  amt;
    op = w[15:12];
    d = w[11:8];
    x = w[7:4];
    s = w[3:0];
    av = m_regs[d];
    bv = m_regs[s];
    simm = {{8{w[7]}}, w[7:0]};
    e = '0;
    e.pc = m_pc;
    nxt = m_pc + 1;
    res = '0;
    case (op)
      4'b0000: begin
        if (x == 4'b1011) cmp_model(av, bv);
        else begin
          alu_model(x, av, bv, res);
          e.reg_wr = 1'b1;
        end
      end
      4'b0100: begin
        case (x)
          4'b0000: begin
            res = m_mem[bv[7:0]];
            e.reg_wr = 1'b1;
          end
          4'b0100: begin
            e.mem_wr = 1'b1;
            m_mem[bv[7:0]] = av;
          end
          4'b1000: begin
            res = m_pc + 1;
            e.reg_wr = 1'b1;
            nxt = bv;
          end
          4'b1100: if (cond_holds(d, m_flags)) nxt = bv;
          default: ;
        endcase
      end
      4'b1000: begin             // Logical shift by a signed amount
        amt = (x == 4'b0100) ? bv[4:0] : simm[4:0];
        res = amt[4] ? (av >> (6'd32 - amt)) : (av << amt);
        e.reg_wr = 1'b1;
      end
      4'b1011: cmp_model(av, simm);
      4'b1100: if (cond_holds(d, m_flags)) nxt = m_pc + simm;
      default: begin
        alu_model(op, av, simm, res);
        e.reg_wr = 1'b1;
      end
    endcase
    e.rdest = d;
    e.wr_data = res;
    e.mem_addr = bv[7:0];
    e.mem_data = av;
    if (e.reg_wr) m_regs[d] = res;
    e.next_pc = nxt;
    e.flags = m_flags;
    m_pc = nxt;
  endtask

  task automatic compare_retire(input retire_t e, input retire_t a);
    string t;
    t = $sformatf("pc %0d", e.pc);
    check_field({t, " pc"}, e.pc, a.pc);
    check_field({t, " next_pc"}, e.next_pc, a.next_pc);
    check_field({t, " flags"}, 16'(e.flags), 16'(a.flags));
    check_field({t, " reg_wr"}, 16'(e.reg_wr), 16'(a.reg_wr));
    check_field({t, " mem_wr"}, 16'(e.mem_wr), 16'(a.mem_wr));
    if (e.reg_wr) begin
      check_field({t, " rdest"}, 16'(e.rdest), 16'(a.rdest));
      check_field({t, " wr_data"}, e.wr_data, a.wr_data);
    end
    if (e.mem_wr) begin
      check_field({t, " mem_addr"}, 16'(e.mem_addr), 16'(a.mem_addr));
      check_field({t, " mem_data"}, e.mem_data, a.mem_data);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Program build and reset
  //////////////////////////////////////////////////////////////////////
  initial begin
    rst = 1'b1;
    inst_valid = 1'b0;
    inst = '0;
    retire_ready = 1'b0;
    held = 1'b0;
    n_prog = 0;
    for (int i = 0; i < 16; i++) m_regs[i] = '0;
    m_flags = '0;
    m_pc = '0;
    emit({ALU_MOV, 4'd1, rand_bits(8)});           // 0 operands
    emit({ALU_MOV, 4'd2, rand_bits(8)});
    emit({ALU_MOV, 4'd3, rand_bits(8)});
    emit({4'b0000, 4'd1, ALU_ADD, 4'd2});          // 3 carry chain
    emit({4'b0000, 4'd3, ALU_ADDC, 4'd2});
    emit({4'b0000, 4'd2, ALU_SUB, 4'd1});          // 5 borrow chain
    emit({4'b0000, 4'd3, ALU_SUBC, 4'd1});
    emit({4'b0000, 4'd1, ALU_AND, 4'd3});
    emit({4'b0000, 4'd2, ALU_OR, 4'd3});
    emit({4'b0000, 4'd3, ALU_XOR, 4'd1});
    emit({4'b0000, 4'd4, ALU_ADDU, 4'd1});         // 10
    emit({ALU_ADD, 4'd1, rand_bits(8)});
    emit({ALU_ADDC, 4'd2, rand_bits(8)});
    emit({ALU_SUB, 4'd3, rand_bits(8)});
    emit({ALU_SUBC, 4'd4, rand_bits(8)});
    emit({ALU_AND, 4'd1, rand_bits(8)});           // 15
    emit({ALU_OR, 4'd2, rand_bits(8)});
    emit({ALU_XOR, 4'd3, rand_bits(8)});
    emit({ALU_MOV, 4'd5, 8'd3});
    emit({4'b1000, 4'd1, 4'b0100, 4'd5});          // 19 left by register
    emit({ALU_MOV, 4'd5, 8'hfc});
    emit({4'b1000, 4'd2, 4'b0100, 4'd5});          // 21 right by register
    emit({4'b1000, 4'd3, 8'h05});                  // LSHI left 5
    emit({4'b1000, 4'd4, 8'hf9});                  // LSHI right 7
    emit({ALU_MOV, 4'd6, 8'h20});
    emit({4'b0100, 4'd1, 4'b0100, 4'd6});          // 25 store then load
    emit({4'b0100, 4'd7, 4'b0000, 4'd6});
    emit({4'b0000, 4'd1, ALU_CMP, 4'd2});
    emit({4'b1100, 4'd14, 8'd2});                  // 28 UC skips 29
    emit({ALU_MOV, 4'd8, 8'd1});
    emit({4'b1100, 4'd15, 8'd2});                  // 30 NV falls through
    emit({OP_CMPI, 4'd1, rand_bits(8)});
    emit({4'b1100, 4'd6, 8'd2});                   // 32 GT
    emit({4'b1100, 4'd10, 8'd2});                  // LO
    emit({ALU_MOV, 4'd9, 8'd37});
    emit({4'b0100, 4'd11, 4'b1100, 4'd9});         // 35 Jcond HS
    emit({ALU_XOR, 4'd1, rand_bits(8)});
    emit({ALU_MOV, 4'd9, 8'd40});
    emit({4'b0100, 4'd11, 4'b1000, 4'd9});         // 38 JAL r11
    emit({ALU_MOV, 4'd8, 8'd2});
    emit({ALU_MOV, 4'd9, 8'd43});                  // 40
    emit({4'b0100, 4'd14, 4'b1100, 4'd9});         // Jcond UC skips 42
    emit({ALU_MOV, 4'd8, 8'd3});
    emit({4'b0100, 4'd15, 4'b1100, 4'd9});         // 43 Jcond NV
    emit({4'b0000, 4'd11, ALU_ADD, 4'd1});
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      if (i > 0) begin            // Registers settle after the first edge
        assert (!retire_valid && !inst_ready && fetch_pc == 16'd0) else
          fail_now("Core left its reset state while reset was held");
      end
    end
    rst <= 1'b0;
    while (!(m_pc == PROG_LEN && exp_q.size() == 0)) @(posedge clk);
    repeat (3) @(posedge clk);
    if (!retire_valid) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      fail_now("Retire stream still valid after the last instruction retired");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Drive, model and check
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    retire_t e;
    if (!rst) begin
      assert (fetch_pc === m_pc) else
        fail_now($sformatf("Mismatch fetch_pc: expected %h, actual %h", m_pc, fetch_pc));
      assert (!(inst_valid && inst_ready && retire_valid && !retire_ready)) else
        fail_now("Instruction accepted while the retire stream was stalled");
      if (held) begin                // Stalled record must hold
        assert (retire_valid && retire === held_rec) else
          fail_now("Retire record changed or dropped while stalled");
      end
      held = retire_valid && !retire_ready;
      held_rec = retire;
      if (retire_valid && retire_ready) begin
        assert (exp_q.size() > 0) else
          fail_now("Retire record with no accepted instruction");
        compare_retire(exp_q.pop_front(), retire);
      end
      if (inst_valid && inst_ready) begin
        model_step(inst.word, e);
        exp_q.push_back(e);
      end
      if (!(inst_valid && !inst_ready)) begin  // No beat pending
        inst_valid <= (m_pc < PROG_LEN) && (rand_bits(2) != 2'd0);
        inst.word  <= prog[m_pc[5:0]];
      end
      retire_ready <= (rand_bits(2) != 2'd0);   // Low about a quarter
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) fail_now("Timeout, program did not finish");
  end

endmodule

`default_nettype wire

// ==== cpu16_core.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu16_macros.svh"

module cpu16_core
  import cpu16_isa_pkg::*;
  import cpu16_bus_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  output logic [`CPU16_DATA_W-1:0] fetch_pc,
  input  logic                     inst_valid,
  input  inst_beat_t               inst,
  output logic                     inst_ready,
  output logic                     retire_valid,
  output retire_t                  retire,
  input  logic                     retire_ready
);

  localparam int W      = `CPU16_DATA_W;
  localparam int IMM_W  = `CPU16_IMM_W;
  localparam int MEM_AW = $clog2(`CPU16_DMEM_DEPTH);

  ctrl_t        ctrl;
  flags_t       flags;
  logic         commit;
  logic         run_q;      // Low until the first cycle out of reset
  logic [W-1:0] a_data, b_data, alu_b, alu_result, mem_r_data;
  logic [W-1:0] result, pc_inc, next_pc;
  retire_t      rec, retire_q;

  ////////////////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////////////////
  assign inst_ready = run_q && (!retire_valid || retire_ready);
  assign commit     = inst_valid && inst_ready;  // Execute and commit this edge

  always_ff @(posedge clk) begin
    if (rst) run_q <= 1'b0;
    else     run_q <= 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////
  control u_control (.inst(inst.word), .ctrl(ctrl));

  reg_file u_reg_file (
    .clk(clk), .rst(rst), .we(commit && ctrl.reg_wr_en),
    .a_addr(ctrl.a_reg), .b_addr(ctrl.b_reg), .w_addr(ctrl.a_reg),
    .w_data(result), .a_data(a_data), .b_data(b_data)
  );

  assign alu_b = ctrl.imm_en ? {{(W - IMM_W){ctrl.imm[IMM_W-1]}}, ctrl.imm} : b_data;

  alu u_alu (
    .clk(clk), .rst(rst), .a(a_data), .b(alu_b), .op(ctrl.alu_op),
    .flag_en(ctrl.alu_flag_en), .commit(commit), .result(alu_result), .flags(flags)
  );

  pc_unit u_pc_unit (
    .clk(clk), .rst(rst), .commit(commit), .pc_op(ctrl.pc_op), .pc_cond(ctrl.pc_cond),
    .cond(cond_e'(ctrl.a_reg)), .flags(flags), .imm(ctrl.imm), .target(b_data),
    .pc(fetch_pc), .next_pc(next_pc)
  );

  data_mem u_data_mem (
    .clk(clk), .we(commit && ctrl.mem_wr_en), .addr(b_data[MEM_AW-1:0]),
    .w_data(a_data), .r_data(mem_r_data)
  );

  // Result bus
  assign pc_inc = fetch_pc + 1'b1;  // JAL link value

  always_comb begin
    if (ctrl.alu_result_en)     result = alu_result;
    else if (ctrl.mem_rd_en)    result = mem_r_data;
    else if (ctrl.pc_result_en) result = pc_inc;
    else                        result = '0;
  end

  ////////////////////////////////////////////////////////////////////////
  // Retire register
  ////////////////////////////////////////////////////////////////////////
  always_comb begin
    rec          = '0;       // Flags filled in at the output
    rec.pc       = fetch_pc;
    rec.reg_wr   = ctrl.reg_wr_en;
    rec.rdest    = ctrl.a_reg;
    rec.wr_data  = result;
    rec.mem_wr   = ctrl.mem_wr_en;
    rec.mem_addr = b_data[MEM_AW-1:0];
    rec.mem_data = a_data;   // Store source
    rec.next_pc  = next_pc;
  end

  always_ff @(posedge clk) begin
    if (rst)               retire_valid <= 1'b0;
    else if (commit)       retire_valid <= 1'b1;
    else if (retire_ready) retire_valid <= 1'b0;  // Drained, nothing new
  end

  always_ff @(posedge clk) begin
    if (commit) retire_q <= rec;
  end

  // Flag register only moves on commit, so it matches the held record
  always_comb begin
    retire       = retire_q;
    retire.flags = flags;
  end

endmodule

`default_nettype wire

// ==== data_mem.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu16_macros.svh"

module data_mem (
  input  logic                                 clk,
  input  logic                                 we,
  input  logic [$clog2(`CPU16_DMEM_DEPTH)-1:0] addr,
  input  logic [`CPU16_DATA_W-1:0]             w_data,
  output logic [`CPU16_DATA_W-1:0]             r_data
);

  logic [`CPU16_DATA_W-1:0] mem [`CPU16_DMEM_DEPTH];

  assign r_data = mem[addr];  // Read same cycle

  always_ff @(posedge clk) begin
    if (we) mem[addr] <= w_data;
  end

endmodule

`default_nettype wire

// ==== pc_unit.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu16_macros.svh"

module pc_unit import cpu16_isa_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     commit,
  input  pc_op_e                   pc_op,
  input  logic                     pc_cond,
  input  cond_e                    cond,
  input  flags_t                   flags,
  input  logic [`CPU16_IMM_W-1:0]  imm,      // Branch displacement
  input  logic [`CPU16_DATA_W-1:0] target,   // Jump target register
  output logic [`CPU16_DATA_W-1:0] pc,
  output logic [`CPU16_DATA_W-1:0] next_pc
);

  localparam int W     = `CPU16_DATA_W;
  localparam int IMM_W = `CPU16_IMM_W;

  logic         cond_true;
  logic [W-1:0] pc_inc;

  assign pc_inc = pc + 1'b1;

  always_comb begin
    case (cond)
      COND_EQ: cond_true = flags.z;
      COND_NE: cond_true = !flags.z;
      COND_CS: cond_true = flags.c;
      COND_CC: cond_true = !flags.c;
      COND_HI: cond_true = flags.l;
      COND_LS: cond_true = !flags.l;
      COND_GT: cond_true = flags.n;
      COND_LE: cond_true = !flags.n;
      COND_FS: cond_true = flags.f;
      COND_FC: cond_true = !flags.f;
      COND_LO: cond_true = !flags.z && !flags.l;
      COND_HS: cond_true = flags.z || flags.l;
      COND_LT: cond_true = !flags.z && !flags.n;
      COND_GE: cond_true = flags.z || flags.n;
      COND_UC: cond_true = 1'b1;  // Always
      default: cond_true = 1'b0;  // NV
    endcase
  end

  // Next pc select, failed condition falls through
  always_comb begin
    if (pc_cond && !cond_true) begin
      next_pc = pc_inc;
    end else begin
      case (pc_op)
        PC_HOLD:   next_pc = pc;
        PC_INC:    next_pc = pc_inc;
        PC_BRANCH: next_pc = pc + {{(W - IMM_W){imm[IMM_W-1]}}, imm};
        default:   next_pc = target;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst)         pc <= '0;
    else if (commit) pc <= next_pc;
  end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu16_macros.svh"

module reg_file (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           we,      // Already qualified by commit
  input  logic [$clog2(`CPU16_REGS)-1:0] a_addr,
  input  logic [$clog2(`CPU16_REGS)-1:0] b_addr,
  input  logic [$clog2(`CPU16_REGS)-1:0] w_addr,
  input  logic [`CPU16_DATA_W-1:0]       w_data,
  output logic [`CPU16_DATA_W-1:0]       a_data,
  output logic [`CPU16_DATA_W-1:0]       b_data
);

  logic [`CPU16_DATA_W-1:0] regs [`CPU16_REGS];

  // Two async read ports
  assign a_data = regs[a_addr];
  assign b_data = regs[b_addr];

  always_ff @(posedge clk) begin
    if (rst)     regs <= '{default: '0};
    else if (we) regs[w_addr] <= w_data;
  end

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu16_macros.svh"

module alu import cpu16_isa_pkg::*; (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`CPU16_DATA_W-1:0] a,        // Dest register value
  input  logic [`CPU16_DATA_W-1:0] b,        // Source register or immediate
  input  alu_op_e                  op,
  input  logic                     flag_en,
  input  logic                     commit,
  output logic [`CPU16_DATA_W-1:0] result,
  output flags_t                   flags
);

  localparam int W = `CPU16_DATA_W;

  logic [W:0] sum;        // Carry or borrow in the top bit
  logic [4:0] shamt;      // Signed shift amount
  flags_t     flags_nx;

  assign shamt = b[4:0];

  always_comb begin
    sum      = '0;
    result   = a;         // Unknown ops leave the register as is
    flags_nx = flags;     // Bits an op does not touch are kept
    case (op)
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_MOV: result = b;
      ALU_ADD, ALU_ADDU, ALU_ADDC: begin
        sum    = {1'b0, a} + {1'b0, b} + (W + 1)'((op == ALU_ADDC) & flags.c);
        result = sum[W-1:0];
        if (op != ALU_ADDU) begin  // ADDU leaves flags alone
          flags_nx.c = sum[W];
          flags_nx.f = (a[W-1] == b[W-1]) && (result[W-1] != a[W-1]);
          flags_nx.z = (result == '0);
          flags_nx.n = result[W-1];
        end
      end
      ALU_SUB, ALU_SUBC: begin
        sum        = {1'b0, a} - {1'b0, b} - (W + 1)'((op == ALU_SUBC) & flags.c);
        result     = sum[W-1:0];
        flags_nx.c = sum[W];  // Borrow out
        flags_nx.f = (a[W-1] != b[W-1]) && (result[W-1] != a[W-1]);
        flags_nx.z = (result == '0);
        flags_nx.n = result[W-1];
      end
      ALU_CMP: begin
        sum        = {1'b0, a} - {1'b0, b};
        result     = sum[W-1:0];
        flags_nx.z = (a == b);
        flags_nx.l = (b < a);                  // Unsigned
        flags_nx.n = ($signed(b) < $signed(a));
        flags_nx.f = (a[W-1] != b[W-1]) && (result[W-1] != a[W-1]);
      end
      ALU_SHIFT: begin
        if (shamt[4]) result = a >> 5'(~shamt + 5'd1);  // Negative, right
        else          result = a << shamt;
      end
      default: begin
      end
    endcase
  end

  // Flag register
  always_ff @(posedge clk) begin
    if (rst)                   flags <= '0;
    else if (commit && flag_en) flags <= flags_nx;
  end

endmodule

`default_nettype wire

// ==== control.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "cpu16_macros.svh"

// Instruction formats
//   arith  {0000  rdest aluop rsrc }    arithI {aluop rdest immh  imml }
//   LSH    {1000  rdest 0100  ramnt}    LSHI   {1000  rdest 000s  imm  }
//   CMP    {0000  rdest 1011  rsrc }    CMPI   {1011  rdest immh  imml }
//   LOAD   {0100  rdest 0000  raddr}    STORE  {0100  rsrc  0100  raddr}
//   Bcond  {1100  cond  disph displ}    Jcond  {0100  cond  1100  rtrgt}
//   JAL    {0100  rlink 1000  rtrgt}

module control import cpu16_isa_pkg::*; (
  input  logic [`CPU16_DATA_W-1:0] inst,
  output ctrl_t                    ctrl
);

  opcode_e           op;
  logic [REG_AW-1:0] dest;
  ext_e              ext;
  logic [REG_AW-1:0] src;

  assign op   = opcode_e'(inst[15:12]);
  assign dest = inst[11:8];
  assign ext  = ext_e'(inst[7:4]);
  assign src  = inst[3:0];

  always_comb begin
    ctrl = '0;

    //////////////////////////////////////////////////////////////////////
    // Fields taken straight from the word
    //////////////////////////////////////////////////////////////////////
    ctrl.alu_op = (op == OP_REGISTER) ? alu_op_e'(ext) : alu_op_e'(op);
    ctrl.a_reg  = dest;
    ctrl.b_reg  = src;
    ctrl.imm    = {ext, src};
    ctrl.pc_op  = PC_INC;  // Default fall through

    //////////////////////////////////////////////////////////////////////
    // Enables per instruction class
    //////////////////////////////////////////////////////////////////////
    case (op)
      OP_BCOND: begin
        ctrl.pc_cond = 1'b1;
        ctrl.pc_op   = PC_BRANCH;  // pc + displacement
      end
      OP_CMPI: begin
        ctrl.imm_en      = 1'b1;
        ctrl.alu_flag_en = 1'b1;   // Flags only, no writeback
      end
      OP_SHIFT: begin
        ctrl.imm_en        = (ext != EXT_LSH);  // LSHI carries the amount inline
        ctrl.alu_result_en = 1'b1;
        ctrl.reg_wr_en     = 1'b1;
      end
      OP_SPECIAL: begin
        case (ext)
          EXT_JCOND: begin
            ctrl.pc_cond = 1'b1;
            ctrl.pc_op   = PC_JMP;
          end
          EXT_JAL: begin
            ctrl.pc_result_en = 1'b1;  // Link value pc+1
            ctrl.reg_wr_en    = 1'b1;
            ctrl.pc_op        = PC_JMP;
          end
          EXT_LOAD: begin
            ctrl.mem_rd_en = 1'b1;     // mem[b_reg] -> a_reg
            ctrl.reg_wr_en = 1'b1;
          end
          EXT_STORE: begin
            ctrl.mem_wr_en = 1'b1;     // a_reg -> mem[b_reg]
          end
          default: begin
            // Unknown extension, retires as a no-op
          end
        endcase
      end
      OP_REGISTER: begin
        ctrl.alu_flag_en = 1'b1;
        if (ext != EXT_CMP) begin
          ctrl.alu_result_en = 1'b1;
          ctrl.reg_wr_en     = 1'b1;
        end
      end
      default: begin  // Remaining opcodes are immediate ALU ops
        ctrl.imm_en        = 1'b1;
        ctrl.alu_flag_en   = 1'b1;
        ctrl.alu_result_en = 1'b1;
        ctrl.reg_wr_en     = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== cpu16_bus_pkg.sv ====
`default_nettype none
`include "cpu16_macros.svh"

package cpu16_bus_pkg;

  // One instruction word per beat
  typedef struct packed {
    logic [`CPU16_DATA_W-1:0] word;
  } inst_beat_t;

  // What one instruction did, as seen on the retire stream
  typedef struct packed {
    logic [`CPU16_DATA_W-1:0]               pc;
    logic                                   reg_wr;
    logic [$clog2(`CPU16_REGS)-1:0]         rdest;
    logic [`CPU16_DATA_W-1:0]               wr_data;
    logic                                   mem_wr;
    logic [$clog2(`CPU16_DMEM_DEPTH)-1:0]   mem_addr;
    logic [`CPU16_DATA_W-1:0]               mem_data;
    logic [`CPU16_DATA_W-1:0]               next_pc;
    cpu16_isa_pkg::flags_t                  flags;    // State after the instruction
  } retire_t;

endpackage

`default_nettype wire

// ==== cpu16_isa_pkg.sv ====
`default_nettype none
`include "cpu16_macros.svh"

package cpu16_isa_pkg;

  localparam int REG_AW = $clog2(`CPU16_REGS);

  // Major opcode in bits 15:12
  typedef enum logic [3:0] {
    OP_REGISTER = 4'b0000,
    OP_SPECIAL  = 4'b0100,
    OP_SHIFT    = 4'b1000,
    OP_CMPI     = 4'b1011,
    OP_BCOND    = 4'b1100
  } opcode_e;

  // Extension in bits 7:4
  typedef enum logic [3:0] {
    EXT_LOAD  = 4'b0000,
    EXT_STORE = 4'b0100,
    EXT_JAL   = 4'b1000,
    EXT_CMP   = 4'b1011,
    EXT_JCOND = 4'b1100
  } ext_e;
  localparam ext_e EXT_LSH = EXT_STORE;  // Same code, under the SHIFT opcode

  typedef enum logic [3:0] {
    ALU_AND  = 4'b0001, ALU_OR   = 4'b0010, ALU_XOR  = 4'b0011,
    ALU_ADD  = 4'b0101, ALU_ADDU = 4'b0110, ALU_ADDC = 4'b0111,
    ALU_SHIFT = 4'b1000,
    ALU_SUB  = 4'b1001, ALU_SUBC = 4'b1010, ALU_CMP  = 4'b1011,
    ALU_MOV  = 4'b1101
  } alu_op_e;

  typedef enum logic [1:0] {PC_HOLD, PC_INC, PC_BRANCH, PC_JMP} pc_op_e;

  // Condition codes, carried in the dest field
  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC,
    COND_HI, COND_LS, COND_GT, COND_LE,
    COND_FS, COND_FC, COND_LO, COND_HS,
    COND_LT, COND_GE, COND_UC, COND_NV
  } cond_e;

  typedef struct packed {
    logic c;  // Carry or borrow
    logic l;  // Unsigned less, from CMP
    logic f;  // Signed overflow
    logic z;  // Zero or equal
    logic n;  // Negative or signed less
  } flags_t;

  typedef struct packed {
    alu_op_e                 alu_op;
    logic [REG_AW-1:0]       a_reg;    // Dest, cond, link or store source
    logic [REG_AW-1:0]       b_reg;    // Source, address or jump target
    logic [`CPU16_IMM_W-1:0] imm;
    pc_op_e                  pc_op;
    logic                    pc_cond;  // Apply pc_op only if cond holds
    logic                    imm_en;
    logic                    mem_rd_en;
    logic                    alu_result_en;
    logic                    pc_result_en;
    logic                    reg_wr_en;
    logic                    mem_wr_en;
    logic                    alu_flag_en;
  } ctrl_t;

endpackage

`default_nettype wire

// ==== cpu16_macros.svh ====
`ifndef CPU16_MACROS_SVH
`define CPU16_MACROS_SVH

////////////////////////////////////////////////////////////////////////
// Core dimensions
////////////////////////////////////////////////////////////////////////

// Register and bus word width
`define CPU16_DATA_W 16

// General purpose registers, r0 included
`define CPU16_REGS 16

// Data memory words, addressed by the low address bits
`define CPU16_DMEM_DEPTH 256

// Inline immediate field {ext, src}
`define CPU16_IMM_W 8

`endif
